// File: rtl/rv_params.svh
// core-wide sizes for the rv32i core
// xlen and register count are fixed by the isa, only the reset pc is free to change
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// general registers, x0 included
`define RV_NREGS 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// byte distance to the next sequential instruction
`define RV_INST_STEP 4

`endif

// File: rtl/rv_pkg.sv
// shared types of the rv32i core
// opcode_e lists only the major opcodes this core executes
`include "rv_params.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {R, I, B, U, J, N} inst_type_e;  // N means no-op

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // one decoded instruction with its operands
    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        opcode_e               opcode;
        inst_type_e            fmt;
        alu_op_e               alu_op;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   rs1_val;
        logic [`RV_XLEN-1:0]   rs2_val;
        logic [`RV_XLEN-1:0]   imm;     // already sign-extended
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   next_pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;      // never set for rd 0
        logic [`RV_XLEN-1:0]   wdata;
    } retire_t;

endpackage

// File: rtl/fetch_unit.sv
// pc register and instruction fetch, one request in flight at a time
// the memory must answer each request exactly once, no back-pressure
`timescale 1ns/10ps
`include "rv_params.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               imem_valid,
    input  logic [`RV_XLEN-1:0] imem_data,
    input  logic               retire_valid,
    input  logic [`RV_XLEN-1:0] next_pc,
    output logic               fetch_req,
    output logic [`RV_XLEN-1:0] fetch_addr,
    output logic               inst_valid,
    output logic [`RV_XLEN-1:0] inst_word,
    output logic [`RV_XLEN-1:0] inst_pc
);

    // REQ only right after reset, later requests follow each retire
    typedef enum logic {REQ, WAIT} fetch_state_e;

    fetch_state_e        state;
    logic [`RV_XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= REQ;
            fetch_req <= 1'b0;
        end else begin
            fetch_req <= (state == REQ) || retire_valid;  // one pulse per instruction
            state     <= WAIT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `RV_RESET_PC;
        else if (retire_valid)
            pc <= next_pc;  // ready in time for the next request
    end

    assign fetch_addr = pc;

    // returned word travels with the pc it was fetched from
    always_ff @(posedge clk) begin
        if (reset)
            inst_valid <= 1'b0;
        else
            inst_valid <= imem_valid;
    end

    always_ff @(posedge clk) begin
        if (imem_valid) begin
            inst_word <= imem_data;
            inst_pc   <= pc;
        end
    end

endmodule

// File: rtl/decode_buffer.sv
// decodes the fetched word and holds it with its operands for one instruction
// unknown opcodes become format N and execute as no-ops
`timescale 1ns/10ps
`include "rv_params.svh"

module decode_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [`RV_XLEN-1:0]   inst_word,
    input  logic [`RV_XLEN-1:0]   inst_pc,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    output logic                  dec_valid,
    output rv_pkg::decoded_t      dec
);

    rv_pkg::opcode_e    opcode;
    rv_pkg::inst_type_e fmt;
    rv_pkg::alu_op_e    alu_op;
    logic [2:0]         funct3;
    logic [`RV_XLEN-1:0] imm;

    assign opcode   = rv_pkg::opcode_e'(inst_word[6:0]);
    assign funct3   = inst_word[14:12];
    assign rs1_addr = inst_word[19:15];
    assign rs2_addr = inst_word[24:20];

    always_comb begin
        case (opcode)
            rv_pkg::OP:                fmt = rv_pkg::R;
            rv_pkg::OP_IMM, rv_pkg::JALR: fmt = rv_pkg::I;
            rv_pkg::BRANCH:            fmt = rv_pkg::B;
            rv_pkg::LUI, rv_pkg::AUIPC: fmt = rv_pkg::U;
            rv_pkg::JAL:               fmt = rv_pkg::J;
            default:                   fmt = rv_pkg::N;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_pkg::I: imm = {{20{inst_word[31]}}, inst_word[31:20]};
            rv_pkg::B: imm = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                              inst_word[30:25], inst_word[11:8], 1'b0};
            rv_pkg::U: imm = {inst_word[31:12], 12'b0};
            rv_pkg::J: imm = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                              inst_word[20], inst_word[30:21], 1'b0};
            default:   imm = '0;
        endcase
    end

    // branches and jumps fall back to add for their target sums
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (opcode == rv_pkg::OP || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000: if (opcode == rv_pkg::OP && inst_word[30]) alu_op = rv_pkg::ALU_SUB;
                3'b001: alu_op = rv_pkg::ALU_SLL;
                3'b010: alu_op = rv_pkg::ALU_SLT;
                3'b011: alu_op = rv_pkg::ALU_SLTU;
                3'b100: alu_op = rv_pkg::ALU_XOR;
                3'b101: alu_op = inst_word[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            dec_valid <= 1'b0;
        else
            dec_valid <= inst_valid;  // fresh for exactly one cycle
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec.pc      <= inst_pc;
            dec.opcode  <= opcode;
            dec.fmt     <= fmt;
            dec.alu_op  <= alu_op;
            dec.funct3  <= funct3;
            dec.rd      <= inst_word[11:7];
            dec.rs1_val <= rs1_data;
            dec.rs2_val <= rs2_data;
            dec.imm     <= imm;
        end
    end

endmodule

// File: rtl/reg_file.sv
// 32 integer registers, two async reads and one sync write
`timescale 1ns/10ps
`include "rv_params.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  wen,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `RV_NREGS; k++)
                regs[k] <= '0;
        end else if (wen && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: rtl/exec_unit.sv
// alu, branch resolve and write-back for one decoded instruction
// the register write lands on the same edge that registers the retire record
`timescale 1ns/10ps
`include "rv_params.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dec_valid,
    input  rv_pkg::decoded_t      dec,
    output logic                  wen,
    output logic [`RV_REG_AW-1:0] waddr,
    output logic [`RV_XLEN-1:0]   wdata,
    output logic                  retire_valid,
    output rv_pkg::retire_t       retire
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] wb_data;
    logic                taken;
    logic                is_jump;
    logic                we;

    always_comb begin
        case (dec.fmt)
            rv_pkg::B, rv_pkg::J: alu_a = dec.pc;
            rv_pkg::U: alu_a = (dec.opcode == rv_pkg::LUI) ? '0 : dec.pc;
            default:   alu_a = dec.rs1_val;
        endcase
    end

    assign alu_b = (dec.fmt == rv_pkg::R) ? dec.rs2_val : dec.imm;

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_SUB:  alu_y = alu_a - alu_b;
            rv_pkg::ALU_SLL:  alu_y = alu_a << alu_b[4:0];
            rv_pkg::ALU_SLT:  alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::ALU_SLTU: alu_y = {31'b0, alu_a < alu_b};
            rv_pkg::ALU_XOR:  alu_y = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:  alu_y = alu_a >> alu_b[4:0];
            rv_pkg::ALU_SRA:  alu_y = $signed(alu_a) >>> alu_b[4:0];
            rv_pkg::ALU_OR:   alu_y = alu_a | alu_b;
            rv_pkg::ALU_AND:  alu_y = alu_a & alu_b;
            default:          alu_y = alu_a + alu_b;
        endcase
    end

    // compare the register operands, the alu is busy with the target
    always_comb begin
        taken = 1'b0;
        if (dec.fmt == rv_pkg::B) begin
            case (dec.funct3)
                3'b000:  taken = dec.rs1_val == dec.rs2_val;
                3'b001:  taken = dec.rs1_val != dec.rs2_val;
                3'b100:  taken = $signed(dec.rs1_val) < $signed(dec.rs2_val);
                3'b101:  taken = $signed(dec.rs1_val) >= $signed(dec.rs2_val);
                3'b110:  taken = dec.rs1_val < dec.rs2_val;
                3'b111:  taken = dec.rs1_val >= dec.rs2_val;
                default: taken = 1'b0;  // 010 and 011 are not branches
            endcase
        end
    end

    assign is_jump = (dec.opcode == rv_pkg::JAL) || (dec.opcode == rv_pkg::JALR);
    assign link    = dec.pc + `RV_INST_STEP;
    assign target  = (dec.opcode == rv_pkg::JALR) ? {alu_y[`RV_XLEN-1:1], 1'b0} : alu_y;
    assign next_pc = (is_jump || taken) ? target : link;

    // branches and no-ops leave the registers alone
    assign wb_data = is_jump ? link : alu_y;
    assign we      = (dec.fmt inside {rv_pkg::R, rv_pkg::I, rv_pkg::U, rv_pkg::J})
                     && (dec.rd != '0);

    assign wen   = dec_valid && we;
    assign waddr = dec.rd;
    assign wdata = wb_data;

    always_ff @(posedge clk) begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            retire.pc      <= dec.pc;
            retire.next_pc <= next_pc;
            retire.rd      <= dec.rd;
            retire.we      <= we;
            retire.wdata   <= wb_data;
        end
    end

endmodule

// File: rtl/rv_core.sv
// single-issue rv32i core, fetch to retire in three cycles
// imem_valid must answer a fetch_req and never arrive unrequested
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_valid,
    input  logic [`RV_XLEN-1:0] imem_data,
    output logic                fetch_req,
    output logic [`RV_XLEN-1:0] fetch_addr,
    output logic                retire_valid,
    output rv_pkg::retire_t     retire
);

    logic                  inst_valid;
    logic [`RV_XLEN-1:0]   inst_word;
    logic [`RV_XLEN-1:0]   inst_pc;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic                  dec_valid;
    rv_pkg::decoded_t      dec;
    logic                  wen;
    logic [`RV_REG_AW-1:0] waddr;
    logic [`RV_XLEN-1:0]   wdata;

    fetch_unit u_fetch_unit (
        .clk(clk), .reset(reset),
        .imem_valid(imem_valid), .imem_data(imem_data),
        .retire_valid(retire_valid), .next_pc(retire.next_pc),  // redirect on retire
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_pc(inst_pc)
    );

    decode_buffer u_decode_buffer (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst_word(inst_word), .inst_pc(inst_pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .dec_valid(dec_valid), .dec(dec)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wen(wen), .waddr(waddr), .wdata(wdata)
    );

    exec_unit u_exec_unit (
        .clk(clk), .reset(reset),
        .dec_valid(dec_valid), .dec(dec),
        .wen(wen), .waddr(waddr), .wdata(wdata),
        .retire_valid(retire_valid), .retire(retire)
    );

endmodule

// File: test/rv_iss.svh
// reference rv32i model and random instruction source, included inside the testbench module
// covers only the ops the core executes, every other opcode is a no-op here too
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

logic [`RV_XLEN-1:0] iss_regs [`RV_NREGS] = '{default: '0};

// register-register and register-immediate results from funct3 and funct7
function automatic logic [31:0] alu_result(input logic [31:0] inst, input logic [31:0] a,
                                           input logic [31:0] b);
    case (inst[14:12])
        3'b000: return (inst[5] && inst[30]) ? a - b : a + b;  // sub only for OP
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (inst[30])
                return $signed(a) >>> b[4:0];
            else
                return a >> b[4:0];
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// runs one instruction on the model state and returns what should retire
function automatic rv_pkg::retire_t iss_execute(input logic [31:0] inst, input logic [31:0] pc);
    rv_pkg::retire_t r;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     imm_i;
    logic [31:0]     imm_b;
    logic [31:0]     imm_j;
    logic            taken;
    a     = iss_regs[inst[19:15]];
    b     = iss_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    r.pc      = pc;
    r.next_pc = pc + 4;
    r.rd      = inst[11:7];
    r.we      = 1'b1;
    r.wdata   = pc + 4;  // link value for jumps
    case (inst[6:0])
        rv_pkg::OP:     r.wdata = alu_result(inst, a, b);
        rv_pkg::OP_IMM: r.wdata = alu_result(inst, a, imm_i);
        rv_pkg::LUI:    r.wdata = {inst[31:12], 12'b0};
        rv_pkg::AUIPC:  r.wdata = pc + {inst[31:12], 12'b0};
        rv_pkg::JAL:    r.next_pc = pc + imm_j;
        rv_pkg::JALR:   r.next_pc = (a + imm_i) & ~32'd1;
        rv_pkg::BRANCH: begin
            // funct3 bit 0 inverts eq, lt and ltu
            taken = (inst[14:13] == 2'b00) ? (a == b) :
                    (inst[14:13] == 2'b10) ? ($signed(a) < $signed(b)) : (a < b);
            r.we = 1'b0;
            if (taken ^ inst[12])
                r.next_pc = pc + imm_b;
        end
        default: r.we = 1'b0;
    endcase
    r.we = r.we && (r.rd != 5'd0);
    if (r.we)
        iss_regs[r.rd] = r.wdata;
    return r;
endfunction

// r gives the fields, s picks the kind of instruction
function automatic logic [31:0] random_inst(input logic [31:0] r, input logic [31:0] s);
    logic [31:0] w;
    w = r;
    case (s[3:0])
        4'd0, 4'd1, 4'd2, 4'd3: begin
            w[6:0]   = rv_pkg::OP;
            w[31:25] = {1'b0, s[4] && (w[14:12] == 3'b000 || w[14:12] == 3'b101), 5'b0};
        end
        4'd4, 4'd5, 4'd6, 4'd7: begin
            w[6:0] = rv_pkg::OP_IMM;
            if (w[13:12] == 2'b01)
                w[31:25] = {1'b0, s[4] && w[14], 5'b0};  // legal shift encodings
        end
        4'd8:  w[6:0] = rv_pkg::LUI;
        4'd9:  w[6:0] = rv_pkg::AUIPC;
        4'd10: w[6:0] = rv_pkg::JAL;
        4'd11: begin
            w[6:0]   = rv_pkg::JALR;
            w[14:12] = 3'b000;
        end
        4'd12, 4'd13, 4'd14: begin
            w[6:0] = rv_pkg::BRANCH;
            w[14]  = w[14] | w[13];  // no 010 or 011
        end
        default: begin
            case (s[5:4])
                2'd0:    w[6:0] = 7'b0000011;  // load
                2'd1:    w[6:0] = 7'b0100011;  // store
                2'd2:    w[6:0] = 7'b1110011;  // system
                default: w[6:0] = 7'b0001111;  // fence
            endcase
        end
    endcase
    return w;
endfunction

`endif

// File: test/tb_rv_core.sv
// random rv32i instruction stream checked against the model in rv_iss.svh
// memory answers each fetch after 1 to 4 cycles with a fresh random word
`timescale 1ns/10ps
`include "rv_params.svh"

module tb_rv_core;

    localparam int N_INST     = 2000;
    localparam int TIMEOUT_NS = N_INST * 10 * 8;  // 10 cycles per instruction at 8 ns

    logic                clk = 1'b0;
    logic                reset;
    logic                imem_valid;
    logic [`RV_XLEN-1:0] imem_data;
    logic                fetch_req;
    logic [`RV_XLEN-1:0] fetch_addr;
    logic                retire_valid;
    rv_pkg::retire_t     retire;
    logic [31:0]         rng = 32'h4943;
    int                  retire_count = 0;

    `include "rv_iss.svh"

    rv_core u_rv_core (
        .clk(clk), .reset(reset),
        .imem_valid(imem_valid), .imem_data(imem_data),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .retire_valid(retire_valid), .retire(retire)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (retire_valid === 1'b1)
            retire_count <= retire_count + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_retire(input string name, input rv_pkg::retire_t exp,
                                input rv_pkg::retire_t act);
        // rd and wdata only mean something when a register is written
        if (act.pc !== exp.pc || act.next_pc !== exp.next_pc || act.we !== exp.we
            || (exp.we && (act.rd !== exp.rd || act.wdata !== exp.wdata)))
            abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_fetch_addr(input string name, input logic [`RV_XLEN-1:0] exp,
                                    input logic [`RV_XLEN-1:0] act);
        if (act !== exp)
            abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
    endtask

    initial begin
        logic [31:0]     fields;
        logic [31:0]     inst;
        logic [31:0]     model_pc;
        rv_pkg::retire_t expected;
        int              cycles;
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_data  = '0;
        model_pc   = `RV_RESET_PC;
        repeat (5) begin
            @(negedge clk);
            if (fetch_req !== 1'b0 || retire_valid !== 1'b0)
                abort_run("fetch_req or retire_valid went high during reset");
        end
        reset = 1'b0;
        for (int n = 0; n < N_INST; n++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (fetch_req !== 1'b1);
            check_count("fetch_req delay", 1, cycles);  // after reset or after retire
            check_fetch_addr("fetch_addr", model_pc, fetch_addr);
            rng = xorshift(rng);
            repeat (rng % 4) @(negedge clk);  // memory latency
            rng    = xorshift(rng);
            fields = rng;
            rng    = xorshift(rng);
            inst   = random_inst(fields, rng);
            imem_valid = 1'b1;
            imem_data  = inst;
            @(negedge clk);
            imem_valid = 1'b0;
            cycles = 1;
            while (retire_valid !== 1'b1) begin
                @(negedge clk);
                cycles++;
            end
            check_count("retire latency", 3, cycles);
            expected = iss_execute(inst, model_pc);
            check_retire("retire", expected, retire);
            model_pc = expected.next_pc;
        end
        repeat (4) @(negedge clk);
        check_count("retire count", N_INST, retire_count);
        $display("Test OK");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog expired before all instructions retired");
    end

endmodule

// File: verilog.f
+incdir+rtl
+incdir+test
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/decode_buffer.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/rv_core.sv
test/tb_rv_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_rv_core -f verilog.f &&
./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -q "Test OK" ||
{ echo "simulation did not pass"; exit 1; }
